// ==== bench/ch3_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_properties (
	input logic                  cery_2mhz,
	input logic                  rst_n,
	input logic                  trig,
	input apu_reg_pkg::ch3_cfg_t cfg,
	input ch3_pkg::ch3_step_t    timing,
	input ch3_pkg::ch3_out_t     ch_out
);

	// dac off clears active, then the sample register one cycle later
	quiet_when_off: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		!cfg.dac_en |=> ##1 (ch_out.sample == 4'd0))
		else $error("sample is nonzero while the channel is inactive");

	// only the top frequency reloads to the overflow value
	step_spacing: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		(timing.step && $past(timing.step)) |-> (cfg.freq == 11'h7FF))
		else $error("step pulsed on consecutive cycles below freq 2047");

	trig_single: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		trig |=> !trig)
		else $error("trigger pulse lasted more than one cycle");

endmodule

bind ch3_top ch3_properties props0 (.cery_2mhz, .rst_n, .trig, .cfg, .timing, .ch_out);

`default_nettype wire

// ==== bench/ch3_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_tb;

	import apu_reg_pkg::*;
	import ch3_pkg::*;

	localparam logic [2:0] OP_WR   = 3'd0;
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_PLAY = 3'd2; // trigger and observe, data holds volume code
	localparam logic [2:0] OP_TICK = 3'd3;
	localparam logic [2:0] OP_ACT  = 3'd4; // exp[0] is the expected active flag
	localparam int MAX_ROWS   = 80;
	localparam int RESET_CYC  = 3;
	localparam int PLAY_STEPS = 64;
	localparam int STEP_CYC   = 8; // 2048 - 2040

	typedef struct packed {
		logic [2:0] op;
		addr_t      addr;
		logic [7:0] data;
		logic [7:0] want;
	} row_t;

	logic       cery_2mhz;
	logic       rst_n;
	addr_t      reg_addr;
	logic [7:0] wr_data;
	logic       wr;
	logic       rd;
	logic       len_tick;
	logic [7:0] rd_data;
	ch3_out_t   ch_out;

	row_t       table_rows [MAX_ROWS];
	logic [3:0] wave_nib [32]; // model of the wave RAM in playback order
	row_t       row;
	logic [7:0] got;
	integer     seed;
	int         n_rows;
	int         total_cyc;
	int         limit;
	int         cyc;
	int         errors;
	int         r;

	ch3_top dut0 (.cery_2mhz, .rst_n, .reg_addr, .wr_data, .wr, .rd, .len_tick, .rd_data, .ch_out);

	initial begin
		cery_2mhz = 1'b0;
		forever #2 cery_2mhz = ~cery_2mhz;
	end

	always @(posedge cery_2mhz) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("timeout: the run went past %0d cycles without finishing", limit);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	task automatic check_eq(input logic [7:0] got_val, input logic [7:0] want_val,
		input string msg);
		if (got_val !== want_val) begin
			errors++;
			$display("FAIL %0t ns: %s, got %02h expected %02h", $time, msg, got_val, want_val);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int row_cycles(input logic [2:0] op);
		case (op)
			OP_RD:   return 1;
			OP_PLAY: return 2 + 10 + PLAY_STEPS * STEP_CYC;
			OP_ACT:  return 3;
			default: return 1;
		endcase
	endfunction

	function automatic void add_row(input logic [2:0] op, input addr_t addr,
		input logic [7:0] data, input logic [7:0] want);
		table_rows[n_rows] = '{op, addr, data, want};
		n_rows++;
		total_cyc += row_cycles(op);
	endfunction

	// expected output for nibble p under a volume code
	function automatic logic [3:0] scaled_nibble(input logic [1:0] code, input int p);
		case (code)
			2'd0:    return 4'd0;
			2'd1:    return wave_nib[p];
			2'd2:    return wave_nib[p] >> 1;
			default: return wave_nib[p] >> 2;
		endcase
	endfunction

	function automatic void build_table();
		logic [3:0] nib;
		for (int p = 0; p < 32; p++) begin
			nib = 4'($random(seed));
			while ((p > 0 && nib == wave_nib[p-1]) || (p == 31 && nib == wave_nib[0]))
				nib = nib + 4'd1; // neighbours differ, wrap included
			wave_nib[p] = nib;
		end
		add_row(OP_WR, 8'h1A, 8'h00, 8'h00);
		add_row(OP_RD, 8'h1A, 8'h00, 8'h7F);
		add_row(OP_WR, 8'h1A, 8'h80, 8'h00);
		add_row(OP_RD, 8'h1A, 8'h00, 8'hFF);
		add_row(OP_WR, 8'h1B, 8'h12, 8'h00);
		add_row(OP_RD, 8'h1B, 8'h00, 8'hFF); // write only
		add_row(OP_WR, 8'h1C, 8'h40, 8'h00);
		add_row(OP_RD, 8'h1C, 8'h00, 8'hDF);
		add_row(OP_WR, 8'h1C, 8'h20, 8'h00);
		add_row(OP_RD, 8'h1C, 8'h00, 8'hBF);
		add_row(OP_WR, 8'h1D, 8'h34, 8'h00);
		add_row(OP_RD, 8'h1D, 8'h00, 8'hFF); // write only
		add_row(OP_WR, 8'h1E, 8'h05, 8'h00);
		add_row(OP_RD, 8'h1E, 8'h00, 8'hBF);
		add_row(OP_WR, 8'h1E, 8'h45, 8'h00);
		add_row(OP_RD, 8'h1E, 8'h00, 8'hFF);
		add_row(OP_RD, 8'h20, 8'h00, 8'hFF); // unmapped
		for (int b = 0; b < 16; b++)
			add_row(OP_WR, addr_t'(8'h30 + b), {wave_nib[2*b], wave_nib[2*b+1]}, 8'h00);
		for (int b = 0; b < 16; b++)
			add_row(OP_RD, addr_t'(8'h30 + b), 8'h00, {wave_nib[2*b], wave_nib[2*b+1]});
		add_row(OP_WR, 8'h1A, 8'h80, 8'h00); // dac on
		add_row(OP_WR, 8'h1D, 8'hF8, 8'h00); // freq 2040 with high bits 7 from the trigger
		add_row(OP_PLAY, 8'h00, 8'd1, 8'h00);
		add_row(OP_PLAY, 8'h00, 8'd0, 8'h00);
		add_row(OP_PLAY, 8'h00, 8'd2, 8'h00);
		add_row(OP_PLAY, 8'h00, 8'd3, 8'h00);
		add_row(OP_WR, 8'h1B, 8'd250, 8'h00); // 6 ticks left
		add_row(OP_WR, 8'h1E, 8'hC7, 8'h00);
		add_row(OP_ACT, 8'h00, 8'h00, 8'h01);
		for (int t = 0; t < 6; t++)
			add_row(OP_TICK, 8'h00, 8'h00, 8'h00);
		add_row(OP_ACT, 8'h00, 8'h00, 8'h00);
		add_row(OP_WR, 8'h1E, 8'hC7, 8'h00);
		add_row(OP_ACT, 8'h00, 8'h00, 8'h01);
		add_row(OP_WR, 8'h1A, 8'h00, 8'h00);
		add_row(OP_ACT, 8'h00, 8'h00, 8'h00);
	endfunction

	// all bus tasks start and end 1 ns after a rising edge
	task automatic write_reg(input addr_t addr, input logic [7:0] data);
		reg_addr = addr;
		wr_data  = data;
		wr       = 1'b1;
		@(posedge cery_2mhz);
		#1;
		wr = 1'b0;
	endtask

	task automatic read_reg(input addr_t addr, output logic [7:0] data);
		reg_addr = addr;
		rd       = 1'b1;
		@(posedge cery_2mhz);
		#1;
		rd   = 1'b0;
		data = rd_data; // registered on that edge
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge cery_2mhz);
		#1;
	endtask

	task automatic pulse_tick();
		len_tick = 1'b1;
		@(posedge cery_2mhz);
		#1;
		len_tick = 1'b0;
	endtask

	task automatic play_and_check(input logic [1:0] code);
		write_reg(8'h1C, {1'b0, code, 5'd0});
		write_reg(8'h1E, 8'h87);
		idle(10); // first step plus one for the sample register
		for (int k = 0; k < PLAY_STEPS; k++) begin
			check_eq({4'd0, ch_out.sample}, {4'd0, scaled_nibble(code, (k + 1) % 32)},
				$sformatf("volume %0d step %0d", code, k));
			if (k < PLAY_STEPS - 1)
				idle(STEP_CYC);
		end
	endtask

	task automatic expect_active(input logic want_act);
		idle(3);
		check_eq({7'd0, ch_out.active}, {7'd0, want_act}, "active flag");
		if (!want_act)
			check_eq({4'd0, ch_out.sample}, 8'h00, "sample of silent channel");
	endtask

	initial begin
		rst_n     = 1'b0;
		reg_addr  = '0;
		wr_data   = '0;
		wr        = 1'b0;
		rd        = 1'b0;
		len_tick  = 1'b0;
		seed      = 32'hfefb_ef02;
		errors    = 0;
		cyc       = 0;
		n_rows    = 0;
		total_cyc = RESET_CYC + 1;
		build_table();
		limit = 2 * total_cyc;
		idle(RESET_CYC);
		rst_n = 1'b1;
		for (r = 0; r < n_rows; r++) begin
			row = table_rows[r];
			case (row.op)
				OP_WR:   write_reg(row.addr, row.data);
				OP_RD: begin
					read_reg(row.addr, got);
					check_eq(got, row.want, $sformatf("read of %02h", row.addr));
				end
				OP_PLAY: play_and_check(row.data[1:0]);
				OP_TICK: pulse_tick();
				default: expect_active(row.want[0]);
			endcase
		end
		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// ==== ch3_top.f ====
source/apu_reg_pkg.sv
source/ch3_pkg.sv
source/ch3_regs.sv
source/ch3_freq_timer.sv
source/ch3_length.sv
source/ch3_wave_out.sv
source/ch3_top.sv
bench/ch3_properties.sv
bench/ch3_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the channel 3 testbench with Verilator, run from the project root
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module ch3_tb -f ch3_top.f -o ch3_sim ||
	{ echo "build failed"; exit 1; }
./obj_dir/ch3_sim > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } ||
	{ echo "simulation passed"; exit 0; }

// ==== source/apu_reg_pkg.sv ====
`default_nettype none

package apu_reg_pkg;

	// low byte of the sound register page
	typedef logic [7:0] addr_t;

	localparam addr_t NR30_ADDR = 8'h1A; // dac enable
	localparam addr_t NR31_ADDR = 8'h1B; // length load
	localparam addr_t NR32_ADDR = 8'h1C; // volume code
	localparam addr_t NR33_ADDR = 8'h1D; // frequency low
	localparam addr_t NR34_ADDR = 8'h1E; // trigger, length enable, frequency high
	localparam addr_t WAVE_BASE = 8'h30; // first wave RAM byte

	// bits that are 1 here always read back as 1
	localparam logic [7:0] NR30_RMASK = 8'h7F;
	localparam logic [7:0] NR31_RMASK = 8'hFF; // write only
	localparam logic [7:0] NR32_RMASK = 8'h9F;
	localparam logic [7:0] NR33_RMASK = 8'hFF; // write only
	localparam logic [7:0] NR34_RMASK = 8'hBF;

	typedef struct packed {
		logic        dac_en;   // NR30 bit 7
		logic [7:0]  len_load; // NR31
		logic [1:0]  vol_code; // NR32 bits 6:5
		logic [10:0] freq;     // NR34 bits 2:0 over NR33
		logic        len_en;   // NR34 bit 6
	} ch3_cfg_t;

endpackage

`default_nettype wire

// ==== source/ch3_freq_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_freq_timer #(
	parameter int FREQ_W = 11
) (
	input  logic                cery_2mhz,
	input  logic                rst_n,
	input  logic [FREQ_W-1:0]   freq,
	input  logic                trig,
	output ch3_pkg::ch3_step_t  timing
);

	import ch3_pkg::*;

	logic [FREQ_W-1:0] cnt;
	logic              overflow;
	logic              trig_q;

	assign overflow = (cnt == '1); // last count before wrap

	// counts up from freq, so the period is 2^FREQ_W - freq cycles
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			cnt    <= '0;
			trig_q <= 1'b0;
		end else begin
			trig_q <= trig; // lines the restart up behind the reload
			if (trig || overflow) begin
				cnt <= freq;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign timing.step    = overflow;
	assign timing.trigger = trig_q;

endmodule

`default_nettype wire

// ==== source/ch3_length.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_length (
	input  logic                  cery_2mhz,
	input  logic                  rst_n,
	input  apu_reg_pkg::ch3_cfg_t cfg,
	input  logic                  trig,
	input  logic                  len_load_wr,
	input  logic                  len_tick,
	output logic                  active
);

	import apu_reg_pkg::*;

	logic [8:0] len_cnt; // 0..256

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			len_cnt <= '0;
		end else if (len_load_wr) begin
			len_cnt <= 9'd256 - {1'b0, cfg.len_load};
		end else if (trig && (len_cnt == 9'd0)) begin
			len_cnt <= 9'd256; // expired length restarts at full
		end else if (len_tick && cfg.len_en && (len_cnt != 9'd0)) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

	// dac off wins over a trigger in the same cycle
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (!cfg.dac_en) begin
			active <= 1'b0;
		end else if (trig) begin
			active <= 1'b1;
		end else if (cfg.len_en && (len_cnt == 9'd0)) begin
			active <= 1'b0; // length ran out
		end
	end

endmodule

`default_nettype wire

// ==== source/ch3_pkg.sv ====
`default_nettype none

package ch3_pkg;

	// position width follows the default wave RAM size, two nibbles per byte
	localparam int WAVE_BYTES_DEF = 16;
	localparam int WAVE_POS_W     = $clog2(WAVE_BYTES_DEF * 2);

	typedef logic [3:0]            sample_t;
	typedef logic [WAVE_POS_W-1:0] wave_pos_t;
	typedef logic [1:0]            vol_code_t;

	typedef struct packed {
		logic step;    // advance one nibble
		logic trigger; // restart at position 0
	} ch3_step_t;

	typedef struct packed {
		sample_t sample;
		logic    active;
	} ch3_out_t;

endpackage

`default_nettype wire

// ==== source/ch3_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_regs (
	input  logic                  cery_2mhz,
	input  logic                  rst_n,
	input  apu_reg_pkg::addr_t    reg_addr,
	input  logic [7:0]            wr_data,
	input  logic                  wr,
	input  logic                  rd,
	output apu_reg_pkg::ch3_cfg_t cfg,
	output logic                  trig,
	output logic                  len_load_wr,
	output logic [7:0]            reg_rd_data
);

	import apu_reg_pkg::*;

	logic [7:0] rd_mux;

	// register writes, trigger and length load strobes
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			cfg         <= '0;
			trig        <= 1'b0;
			len_load_wr <= 1'b0;
		end else begin
			trig        <= wr && (reg_addr == NR34_ADDR) && wr_data[7]; // cycle after write
			len_load_wr <= wr && (reg_addr == NR31_ADDR); // cfg.len_load valid with it
			if (wr) begin
				case (reg_addr)
					NR30_ADDR: cfg.dac_en <= wr_data[7];
					NR31_ADDR: cfg.len_load <= wr_data;
					NR32_ADDR: cfg.vol_code <= wr_data[6:5];
					NR33_ADDR: cfg.freq[7:0] <= wr_data;
					NR34_ADDR: begin
						cfg.len_en     <= wr_data[6];
						cfg.freq[10:8] <= wr_data[2:0]; // bit 7 is not stored
					end
					default: ;
				endcase
			end
		end
	end

	// readback, unused and write-only bits read as 1
	always_comb begin
		case (reg_addr)
			NR30_ADDR: rd_mux = {cfg.dac_en, 7'd0} | NR30_RMASK;
			NR31_ADDR: rd_mux = cfg.len_load | NR31_RMASK;
			NR32_ADDR: rd_mux = {1'b0, cfg.vol_code, 5'd0} | NR32_RMASK;
			NR33_ADDR: rd_mux = cfg.freq[7:0] | NR33_RMASK;
			NR34_ADDR: rd_mux = {1'b0, cfg.len_en, 3'd0, cfg.freq[10:8]} | NR34_RMASK;
			default:   rd_mux = 8'hFF;
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			reg_rd_data <= '0;
		end else if (rd) begin
			reg_rd_data <= rd_mux; // held until next rd
		end
	end

endmodule

`default_nettype wire

// ==== source/ch3_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_top #(
	parameter int unsigned WAVE_BYTES = 16,
	parameter int          FREQ_W     = 11
) (
	input  logic               cery_2mhz,
	input  logic               rst_n,
	input  apu_reg_pkg::addr_t reg_addr,
	input  logic [7:0]         wr_data,
	input  logic               wr,
	input  logic               rd,
	input  logic               len_tick,
	output logic [7:0]         rd_data,
	output ch3_pkg::ch3_out_t  ch_out
);

	import apu_reg_pkg::*;
	import ch3_pkg::*;

	localparam addr_t      WAVE_LAST = addr_t'(WAVE_BASE + WAVE_BYTES - 1);
	localparam logic [1:0] SEL_REGS  = 2'd0;
	localparam logic [1:0] SEL_WAVE  = 2'd1;
	localparam logic [1:0] SEL_NONE  = 2'd2;

	ch3_cfg_t   cfg;
	logic       trig;
	logic       len_load_wr;
	logic       active;
	ch3_step_t  timing;
	logic [7:0] reg_rd_data;
	logic [7:0] wave_rd_data;
	logic [1:0] rd_sel;

	ch3_regs regs0 (.cery_2mhz, .rst_n, .reg_addr, .wr_data, .wr, .rd,
		.cfg, .trig, .len_load_wr, .reg_rd_data);

	ch3_freq_timer #(.FREQ_W(FREQ_W)) timer0 (.cery_2mhz, .rst_n,
		.freq(cfg.freq), .trig, .timing);

	ch3_length length0 (.cery_2mhz, .rst_n, .cfg, .trig, .len_load_wr, .len_tick, .active);

	ch3_wave_out #(.WAVE_BYTES(WAVE_BYTES)) wave0 (.cery_2mhz, .rst_n, .reg_addr, .wr_data,
		.wr, .rd, .timing, .active, .vol_code(cfg.vol_code), .wave_rd_data, .ch_out);

	// source select captured with the read, both data sources are registered on rd too
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			rd_sel <= SEL_REGS;
		end else if (rd) begin
			if ((reg_addr >= NR30_ADDR) && (reg_addr <= NR34_ADDR)) rd_sel <= SEL_REGS;
			else if ((reg_addr >= WAVE_BASE) && (reg_addr <= WAVE_LAST)) rd_sel <= SEL_WAVE;
			else rd_sel <= SEL_NONE;
		end
	end

	always_comb begin
		case (rd_sel)
			SEL_REGS: rd_data = reg_rd_data;
			SEL_WAVE: rd_data = wave_rd_data;
			default:  rd_data = 8'hFF; // unmapped
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ch3_wave_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch3_wave_out #(
	parameter int unsigned WAVE_BYTES = 16
) (
	input  logic               cery_2mhz,
	input  logic               rst_n,
	input  apu_reg_pkg::addr_t reg_addr,
	input  logic [7:0]         wr_data,
	input  logic               wr,
	input  logic               rd,
	input  ch3_pkg::ch3_step_t timing,
	input  logic               active,
	input  ch3_pkg::vol_code_t vol_code,
	output logic [7:0]         wave_rd_data,
	output ch3_pkg::ch3_out_t  ch_out
);

	import apu_reg_pkg::*;
	import ch3_pkg::*;

	localparam int    IDX_W     = $clog2(WAVE_BYTES);
	localparam addr_t WAVE_LAST = addr_t'(WAVE_BASE + WAVE_BYTES - 1);

	logic [7:0]       wave_ram [WAVE_BYTES];
	logic             wave_hit;
	logic [IDX_W-1:0] bus_idx;
	logic [IDX_W-1:0] play_idx;
	wave_pos_t        pos;
	logic [7:0]       play_byte;
	sample_t          nibble;
	sample_t          shifted;

	assign wave_hit = (reg_addr >= WAVE_BASE) && (reg_addr <= WAVE_LAST);
	assign bus_idx  = IDX_W'(reg_addr - WAVE_BASE);

	always_ff @(posedge cery_2mhz) begin
		if (wr && wave_hit) begin
			wave_ram[bus_idx] <= wr_data;
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			wave_rd_data <= '0;
		end else if (rd) begin
			wave_rd_data <= wave_ram[bus_idx]; // top ignores it outside the range
		end
	end

	// nibble position, trigger has priority over step
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (timing.trigger) begin
			pos <= '0;
		end else if (timing.step) begin
			pos <= pos + 1'b1; // wraps after the last nibble
		end
	end

	assign play_idx  = IDX_W'(pos >> 1);
	assign play_byte = wave_ram[play_idx];
	assign nibble    = pos[0] ? play_byte[3:0] : play_byte[7:4]; // high nibble first

	always_comb begin
		case (vol_code)
			2'd0:    shifted = '0; // mute
			2'd1:    shifted = nibble;
			2'd2:    shifted = nibble >> 1;
			default: shifted = nibble >> 2;
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			ch_out <= '0;
		end else begin
			ch_out.sample <= active ? shifted : '0;
			ch_out.active <= active;
		end
	end

endmodule

`default_nettype wire
